// File: fx3_loopback.f
source/fx3_pkg.sv
source/fx3_bus_capture.sv
source/fx3_loop_buffer.sv
source/fx3_master_fsm.sv
source/fx3_bus_driver.sv
source/fx3_loopback.sv
verification/fx3_device_model.sv
verification/fx3_loopback_tb.sv

// File: Makefile
# Verilator flow for the FX3 slave FIFO loopback

TOP = fx3_loopback_tb

.PHONY: all lint clean

# build, run, then look for the pass line in the log
all:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f fx3_loopback.f -o sim
	./obj_dir/sim | tee sim.log
	grep -q "^TEST PASS$$" sim.log

# RTL only, full warning set
lint:
	verilator --lint-only -Wall --top-module fx3_loopback \
		source/fx3_pkg.sv source/fx3_bus_capture.sv source/fx3_loop_buffer.sv \
		source/fx3_master_fsm.sv source/fx3_bus_driver.sv source/fx3_loopback.sv

clean:
	rm -rf obj_dir sim.log

// File: verification/fx3_loopback_tb.sv
`timescale 1ns/1ps

module fx3_loopback_tb;
    import fx3_pkg::*;

    localparam int SEED           = 13850;
    localparam int CLK_PERIOD     = 100;
    localparam int BURSTS         = 4;
    localparam int TIMEOUT_CYCLES = BURSTS * (3 * BURST_WORDS + 200);

    logic              usb_clk;
    logic              reset_;
    logic              flaga;
    logic              flagb;
    logic              flagc;
    logic              flagd;
    logic [DATA_W-1:0] data_i;
    logic              slcs_n_o;
    logic              slrd_n_o;
    logic              sloe_n_o;
    logic              slwr_n_o;
    logic [ADDR_W-1:0] addr_o;
    logic [DATA_W-1:0] data_o;
    logic              data_oe_o;
    int                bursts_done;
    int                err_cnt;
    int                stall_cnt;
    int                cycles = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                errs_before;
    bit                ok;

    fx3_loopback fx3_loopback_i (
        .usb_clk   (usb_clk),
        .reset_    (reset_),
        .flaga_i   (flaga),
        .flagb_i   (flagb),
        .flagc_i   (flagc),
        .flagd_i   (flagd),
        .data_i    (data_i),
        .slcs_n_o  (slcs_n_o),
        .slrd_n_o  (slrd_n_o),
        .sloe_n_o  (sloe_n_o),
        .slwr_n_o  (slwr_n_o),
        .addr_o    (addr_o),
        .data_o    (data_o),
        .data_oe_o (data_oe_o)
    );

    // controller side, drives flags and data_i from time zero
    fx3_device_model #(.SEED(SEED), .BURSTS(BURSTS)) fx3_device_model_i (
        .usb_clk       (usb_clk),
        .reset_        (reset_),
        .slcs_n_i      (slcs_n_o),
        .slrd_n_i      (slrd_n_o),
        .sloe_n_i      (sloe_n_o),
        .slwr_n_i      (slwr_n_o),
        .addr_i        (addr_o),
        .wr_data_i     (data_o),
        .data_oe_i     (data_oe_o),
        .flaga_o       (flaga),
        .flagb_o       (flagb),
        .flagc_o       (flagc),
        .flagd_o       (flagd),
        .rd_data_o     (data_i),
        .bursts_done_o (bursts_done),
        .err_cnt_o     (err_cnt),
        .stall_cnt_o   (stall_cnt)
    );

    always #(CLK_PERIOD / 2) usb_clk = ~usb_clk;

    // hard stop well past the longest expected run
    always @(posedge usb_clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic bit pin_ok(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s: got %0h, expected %0h", $time, name, got, exp);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // bus parked, nothing selected or strobed
    function automatic bit idle_pins_ok();
        bit res;
        res = pin_ok("slcs_n_o", 32'(slcs_n_o), 32'd1);
        res = pin_ok("slrd_n_o", 32'(slrd_n_o), 32'd1) && res;
        res = pin_ok("sloe_n_o", 32'(sloe_n_o), 32'd1) && res;
        res = pin_ok("slwr_n_o", 32'(slwr_n_o), 32'd1) && res;
        res = pin_ok("data_oe_o", 32'(data_oe_o), 32'd0) && res;
        res = pin_ok("addr_o", 32'(addr_o), 32'(ADDR_IDLE)) && res;
        return res;
    endfunction

    task automatic report(input string name, input bit passed);
        tests_run++;
        if (passed) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        usb_clk = 1'b0;
        reset_ = 1'b0;
        repeat (5) @(posedge usb_clk);
        #1 reset_ = 1'b1;
        // model holds c and d low for at least 8 cycles here
        @(negedge usb_clk);
        report("reset_idle", idle_pins_ok());
        // each burst is framed by the model, read strobes and writes checked there
        for (int b = 0; b < BURSTS; b++) begin
            errs_before = err_cnt;
            // model counters move on the falling edge only
            while (bursts_done <= b) begin
                @(posedge usb_clk);
            end
            // pins settle one cycle after the last write
            repeat (2) @(negedge usb_clk);
            ok = idle_pins_ok();
            report($sformatf("burst_%0d", b), ok && (err_cnt == errs_before));
        end
        if (stall_cnt == 0) begin
            $display("no flag b stall happened during the run");
        end
        report("back_pressure", stall_cnt > 0);
        $display("summary: %0d tests, %0d failed, %0d check errors, %0d stalls",
                 tests_run, tests_failed, err_cnt, stall_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verification/fx3_device_model.sv
`timescale 1ns/1ps

module fx3_device_model #(
    parameter int SEED   = 1,
    parameter int BURSTS = 1
) (
    input  logic                       usb_clk,
    input  logic                       reset_,
    input  logic                       slcs_n_i,
    input  logic                       slrd_n_i,
    input  logic                       sloe_n_i,
    input  logic                       slwr_n_i,
    input  logic [fx3_pkg::ADDR_W-1:0] addr_i,
    input  logic [fx3_pkg::DATA_W-1:0] wr_data_i,
    input  logic                       data_oe_i,
    output logic                       flaga_o,
    output logic                       flagb_o,
    output logic                       flagc_o,
    output logic                       flagd_o,
    output logic [fx3_pkg::DATA_W-1:0] rd_data_o,
    output int                         bursts_done_o,
    output int                         err_cnt_o,
    output int                         stall_cnt_o
);
    import fx3_pkg::*;

    logic [DATA_W-1:0] exp_q[$];
    logic [DATA_W-1:0] word;
    int                rd_cnt;
    int                wr_cnt;
    int                late_wr;
    int                stall_left;
    int                wait_left;
    logic              active;
    logic              pend;
    logic              drive_word;

    // one strobe seen by the controller
    task automatic take_read();
        if (!(flagc_o && flagd_o)) begin
            $display("read strobe at %0t while flags c and d are not both high", $time);
            err_cnt_o++;
        end
        if (addr_i !== ADDR_STREAM_OUT) begin
            $display("FAIL %0t addr_o: got %b, expected %b", $time, addr_i, ADDR_STREAM_OUT);
            err_cnt_o++;
        end
        // selected, and controller driving the bus
        if (slcs_n_i !== 1'b0) begin
            $display("FAIL %0t slcs_n_o: got %b, expected 0", $time, slcs_n_i);
            err_cnt_o++;
        end
        if (sloe_n_i !== 1'b0) begin
            $display("FAIL %0t sloe_n_o: got %b, expected 0", $time, sloe_n_i);
            err_cnt_o++;
        end
        rd_cnt++;
        if (rd_cnt > BURST_WORDS) begin
            $display("read strobe %0d at %0t is beyond the burst length", rd_cnt, $time);
            err_cnt_o++;
        end
    endtask

    // one word accepted into stream-in
    task automatic take_write();
        if (addr_i !== ADDR_STREAM_IN) begin
            $display("FAIL %0t addr_o: got %b, expected %b", $time, addr_i, ADDR_STREAM_IN);
            err_cnt_o++;
        end
        if (data_oe_i !== 1'b1) begin
            $display("FAIL %0t data_oe_o: got %b, expected 1", $time, data_oe_i);
            err_cnt_o++;
        end
        // selected, controller output drivers off
        if (slcs_n_i !== 1'b0) begin
            $display("FAIL %0t slcs_n_o: got %b, expected 0", $time, slcs_n_i);
            err_cnt_o++;
        end
        if (sloe_n_i !== 1'b1) begin
            $display("FAIL %0t sloe_n_o: got %b, expected 1", $time, sloe_n_i);
            err_cnt_o++;
        end
        // flags lag, so two writes may still land after b falls
        if (!flagb_o) begin
            late_wr++;
            if (late_wr > 2) begin
                $display("write %0d after flag b fell, at %0t", late_wr, $time);
                err_cnt_o++;
            end
        end
        if (exp_q.size() == 0) begin
            $display("write at %0t with no read word left to match", $time);
            err_cnt_o++;
        end else begin
            word = exp_q.pop_front();
            if (wr_data_i !== word) begin
                $display("FAIL %0t data_o: got %h, expected %h", $time, wr_data_i, word);
                err_cnt_o++;
            end
        end
        wr_cnt++;
        if (wr_cnt == BURST_WORDS) begin
            if (rd_cnt != BURST_WORDS) begin
                $display("burst ended after %0d read strobes", rd_cnt);
                err_cnt_o++;
            end
            // packet done, idle a while before the next one
            bursts_done_o++;
            rd_cnt = 0;
            wr_cnt = 0;
            active = 1'b0;
            wait_left = $urandom_range(31, 8);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        flaga_o = 1'b1;
        flagb_o = 1'b1;
        flagc_o = 1'b0;
        flagd_o = 1'b0;
        rd_data_o = '0;
        bursts_done_o = 0;
        err_cnt_o = 0;
        stall_cnt_o = 0;
        rd_cnt = 0;
        wr_cnt = 0;
        late_wr = 0;
        stall_left = 0;
        active = 1'b0;
        pend = 1'b0;
        wait_left = $urandom_range(31, 8);
        @(posedge reset_);
        forever begin
            // pins as the controller sees them on the coming edge
            @(negedge usb_clk);
            drive_word = pend;
            pend = !slrd_n_i;
            if (!slrd_n_i) begin
                take_read();
            end
            if (!slwr_n_i) begin
                take_write();
            end
            @(posedge usb_clk);
            #1;
            // word for the strobe two edges back, junk otherwise
            word = $urandom;
            rd_data_o = word;
            if (drive_word) begin
                exp_q.push_back(word);
            end
            // packet flags, dropped once the whole packet was strobed
            if (rd_cnt >= BURST_WORDS) begin
                flagc_o = 1'b0;
                flagd_o = 1'b0;
            end else if (!active && bursts_done_o < BURSTS) begin
                if (wait_left == 0) begin
                    active = 1'b1;
                    flagc_o = 1'b1;
                    flagd_o = 1'b1;
                end else begin
                    wait_left--;
                end
            end
            // random back-pressure during stream-in
            if (stall_left > 0) begin
                stall_left--;
                if (stall_left == 0) begin
                    flagb_o = 1'b1;
                end
            end else if (data_oe_i && $urandom_range(31) == 0) begin
                flagb_o = 1'b0;
                late_wr = 0;
                stall_left = $urandom_range(6, 3);
                stall_cnt_o++;
            end
        end
    end

endmodule

// File: source/fx3_loopback.sv
`timescale 1ns/1ps

module fx3_loopback (
    input  logic                      usb_clk,
    input  logic                      reset_,
    input  logic                      flaga_i,
    input  logic                      flagb_i,
    input  logic                      flagc_i,
    input  logic                      flagd_i,
    input  logic [fx3_pkg::DATA_W-1:0] data_i,
    output logic                      slcs_n_o,
    output logic                      slrd_n_o,
    output logic                      sloe_n_o,
    output logic                      slwr_n_o,
    output logic [fx3_pkg::ADDR_W-1:0] addr_o,
    output logic [fx3_pkg::DATA_W-1:0] data_o,
    output logic                      data_oe_o
);
    import fx3_pkg::*;

    logic              flags_ok_rd;
    logic              flags_ok_wr;
    logic [DATA_W-1:0] rd_word;
    logic              rd_word_valid;
    logic [DATA_W-1:0] buf_rdata;
    logic [CNT_W-1:0]  buf_count;
    logic              buf_empty;
    master_state_t     state;
    logic              rd_issue;
    logic              wr_issue;
    logic              pop;

    // flags and read data in, strobe pin fed back for framing
    fx3_bus_capture fx3_bus_capture_i (
        .usb_clk         (usb_clk),
        .reset_          (reset_),
        .flaga_i         (flaga_i),
        .flagb_i         (flagb_i),
        .flagc_i         (flagc_i),
        .flagd_i         (flagd_i),
        .data_i          (data_i),
        .slrd_n_i        (slrd_n_o),
        .flags_ok_rd_o   (flags_ok_rd),
        .flags_ok_wr_o   (flags_ok_wr),
        .rd_word_o       (rd_word),
        .rd_word_valid_o (rd_word_valid)
    );

    // one burst parked between stream-out and stream-in
    fx3_loop_buffer fx3_loop_buffer_i (
        .usb_clk (usb_clk),
        .reset_  (reset_),
        .push_i  (rd_word_valid),
        .wdata_i (rd_word),
        .pop_i   (pop),
        .rdata_o (buf_rdata),
        .count_o (buf_count),
        .empty_o (buf_empty)
    );

    fx3_master_fsm fx3_master_fsm_i (
        .usb_clk       (usb_clk),
        .reset_        (reset_),
        .flags_ok_rd_i (flags_ok_rd),
        .flags_ok_wr_i (flags_ok_wr),
        .buf_count_i   (buf_count),
        .buf_empty_i   (buf_empty),
        .state_o       (state),
        .rd_issue_o    (rd_issue),
        .wr_issue_o    (wr_issue),
        .pop_o         (pop)
    );

    // pin registers
    fx3_bus_driver fx3_bus_driver_i (
        .usb_clk    (usb_clk),
        .reset_     (reset_),
        .state_i    (state),
        .rd_issue_i (rd_issue),
        .wr_issue_i (wr_issue),
        .wdata_i    (buf_rdata),
        .slcs_n_o   (slcs_n_o),
        .slrd_n_o   (slrd_n_o),
        .sloe_n_o   (sloe_n_o),
        .slwr_n_o   (slwr_n_o),
        .addr_o     (addr_o),
        .data_o     (data_o),
        .data_oe_o  (data_oe_o)
    );

endmodule

// File: source/fx3_bus_driver.sv
`timescale 1ns/1ps

module fx3_bus_driver (
    input  logic                      usb_clk,
    input  logic                      reset_,
    input  fx3_pkg::master_state_t    state_i,
    input  logic                      rd_issue_i,
    input  logic                      wr_issue_i,
    input  logic [fx3_pkg::DATA_W-1:0] wdata_i,
    output logic                      slcs_n_o,
    output logic                      slrd_n_o,
    output logic                      sloe_n_o,
    output logic                      slwr_n_o,
    output logic [fx3_pkg::ADDR_W-1:0] addr_o,
    output logic [fx3_pkg::DATA_W-1:0] data_o,
    output logic                      data_oe_o
);
    import fx3_pkg::*;

    logic [ADDR_W-1:0] addr_nxt;

    // socket select per mode
    always_comb begin
        case (state_i)
            ST_STREAM_OUT: addr_nxt = ADDR_STREAM_OUT;
            ST_STREAM_IN:  addr_nxt = ADDR_STREAM_IN;
            default:       addr_nxt = ADDR_IDLE;
        endcase
    end

    // control pins, all flopped so they move on one edge
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            slcs_n_o  <= 1'b1;
            slrd_n_o  <= 1'b1;
            sloe_n_o  <= 1'b1;
            slwr_n_o  <= 1'b1;
            addr_o    <= ADDR_IDLE;
            data_oe_o <= 1'b0;
        end else begin
            // chip selected whenever a transfer is in progress
            slcs_n_o  <= (state_i == ST_IDLE);
            slrd_n_o  <= ~rd_issue_i;
            // controller drives the bus for the whole stream-out
            sloe_n_o  <= (state_i != ST_STREAM_OUT);
            slwr_n_o  <= ~wr_issue_i;
            addr_o    <= addr_nxt;
            // fpga owns the bus only during stream-in
            data_oe_o <= (state_i == ST_STREAM_IN);
        end
    end

    // write data lines up with slwr_n
    always_ff @(posedge usb_clk) begin
        data_o <= wdata_i;
    end

endmodule

// File: source/fx3_master_fsm.sv
`timescale 1ns/1ps

module fx3_master_fsm (
    input  logic                     usb_clk,
    input  logic                     reset_,
    input  logic                     flags_ok_rd_i,
    input  logic                     flags_ok_wr_i,
    input  logic [fx3_pkg::CNT_W-1:0] buf_count_i,
    input  logic                     buf_empty_i,
    output fx3_pkg::master_state_t   state_o,
    output logic                     rd_issue_o,
    output logic                     wr_issue_o,
    output logic                     pop_o
);
    import fx3_pkg::*;

    master_state_t    state;
    master_state_t    state_nxt;
    logic [CNT_W-1:0] rd_cnt;
    logic [CNT_W-1:0] wr_cnt;
    logic             rd_done;
    logic             wr_last;
    logic             buf_full_burst;
    logic             wr_go;

    // all strobes for this burst already issued
    assign rd_done = (rd_cnt == CNT_W'(BURST_WORDS));
    // the write going out now is the final one
    assign wr_last = (wr_cnt == CNT_W'(BURST_WORDS - 1));
    // every returned word has landed in the buffer
    assign buf_full_burst = (buf_count_i == CNT_W'(BURST_WORDS));

    // read strobes back to back until the burst is issued
    assign rd_issue_o = (state == ST_STREAM_OUT) & ~rd_done;

    // one write decision shared by the buffer pop and the slwr strobe
    // stalls on back-pressure or an empty buffer
    assign wr_go = (state == ST_STREAM_IN) & flags_ok_wr_i & ~buf_empty_i;
    assign wr_issue_o = wr_go;
    assign pop_o      = wr_go;

    assign state_o = state;

    // next mode
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                // packet ready in the controller
                if (flags_ok_rd_i) begin
                    state_nxt = ST_STREAM_OUT;
                end
            end
            ST_STREAM_OUT: begin
                // wait out the read latency
                // leave once the last word is stored
                if (buf_full_burst) begin
                    state_nxt = ST_TURNAROUND;
                end
            end
            ST_TURNAROUND: begin
                // one dead cycle while the controller releases the bus
                state_nxt = ST_STREAM_IN;
            end
            ST_STREAM_IN: begin
                if (wr_go && wr_last) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // mode register and word counters
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            state  <= ST_IDLE;
            rd_cnt <= '0;
            wr_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_IDLE) begin
                // fresh counts for the next burst
                rd_cnt <= '0;
                wr_cnt <= '0;
            end else begin
                if (rd_issue_o) begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
                if (wr_go) begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: source/fx3_loop_buffer.sv
`timescale 1ns/1ps

module fx3_loop_buffer (
    input  logic                      usb_clk,
    input  logic                      reset_,
    input  logic                      push_i,
    input  logic [fx3_pkg::DATA_W-1:0] wdata_i,
    input  logic                      pop_i,
    output logic [fx3_pkg::DATA_W-1:0] rdata_o,
    output logic [fx3_pkg::CNT_W-1:0]  count_o,
    output logic                      empty_o
);
    import fx3_pkg::*;

    logic [DATA_W-1:0]      mem [BUF_DEPTH];
    logic [BUF_DEPTH_W-1:0] wr_ptr;
    logic [BUF_DEPTH_W-1:0] rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign full    = (count == CNT_W'(BUF_DEPTH));
    assign empty_o = (count == '0);
    assign count_o = count;

    // overflow and underflow requests are dropped
    assign do_push = push_i & ~full;
    assign do_pop  = pop_i & ~empty_o;

    // pointers and occupancy
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge usb_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

    // first word falls through, head visible before the pop
    assign rdata_o = mem[rd_ptr];

endmodule

// File: source/fx3_bus_capture.sv
`timescale 1ns/1ps

module fx3_bus_capture (
    input  logic                      usb_clk,
    input  logic                      reset_,
    input  logic                      flaga_i,
    input  logic                      flagb_i,
    input  logic                      flagc_i,
    input  logic                      flagd_i,
    input  logic [fx3_pkg::DATA_W-1:0] data_i,
    input  logic                      slrd_n_i,
    output logic                      flags_ok_rd_o,
    output logic                      flags_ok_wr_o,
    output logic [fx3_pkg::DATA_W-1:0] rd_word_o,
    output logic                      rd_word_valid_o
);
    import fx3_pkg::*;

    logic                    flaga_q;
    logic                    flagb_q;
    logic                    flagc_q;
    logic                    flagd_q;
    logic [READ_LATENCY-1:0] rd_pipe;

    // flags cross into the fsm through one register
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            flaga_q <= 1'b0;
            flagb_q <= 1'b0;
            flagc_q <= 1'b0;
            flagd_q <= 1'b0;
        end else begin
            flaga_q <= flaga_i;
            flagb_q <= flagb_i;
            flagc_q <= flagc_i;
            flagd_q <= flagd_i;
        end
    end

    // c and d high, full packet waiting in stream-out fifo
    assign flags_ok_rd_o = flagc_q & flagd_q;
    // a and b high, stream-in fifo has room
    // b low is back-pressure
    assign flags_ok_wr_o = flaga_q & flagb_q;

    // strobe as the controller saw it, one stage per edge
    // top bit set means data_i holds a real word right now,
    // sampled on the READ_LATENCY-th edge after the strobe
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            rd_pipe <= '0;
            rd_word_valid_o <= 1'b0;
        end else begin
            rd_pipe <= {rd_pipe[READ_LATENCY-2:0], ~slrd_n_i};
            rd_word_valid_o <= rd_pipe[READ_LATENCY-1];
        end
    end

    // payload, taken every cycle and qualified by the valid bit
    always_ff @(posedge usb_clk) begin
        rd_word_o <= data_i;
    end

endmodule

// File: source/fx3_pkg.sv
package fx3_pkg;

    // slave fifo bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 2;

    // controller socket addresses on A1:A0
    // stream-out fifo, controller to fpga
    localparam logic [ADDR_W-1:0] ADDR_STREAM_OUT = 2'b11;
    // stream-in fifo, fpga to controller
    localparam logic [ADDR_W-1:0] ADDR_STREAM_IN = 2'b00;
    // parked address while no transfer runs
    localparam logic [ADDR_W-1:0] ADDR_IDLE = 2'b10;

    // words moved per loop, one full packet
    localparam int BURST_WORDS = 512;

    // loop buffer geometry
    localparam int BUF_DEPTH_W = 9;
    localparam int BUF_DEPTH = 512;

    // edges from slrd_n sampled low to the word being sampled off data_i
    localparam int READ_LATENCY = 2;

    // word counters, wide enough to hold BURST_WORDS itself
    localparam int CNT_W = 10;

    // master mode
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STREAM_OUT,
        ST_TURNAROUND,
        ST_STREAM_IN
    } master_state_t;

endpackage
